// File: common/mcu_pkg.sv
/* shared widths, interrupt bit positions and power sequencer states
   for the always-on glue; imported by the RTL modules that need them */

package mcu_pkg;

  // memory banks with their own power switch
  parameter int unsigned NUM_BANKS = 6;

  parameter int unsigned INTR_W      = 32;
  parameter int unsigned FAST_INTR_W = 15;
  parameter int unsigned NUM_TIMERS  = 4;
  parameter int unsigned NUM_GPIO_AO = 8;

  typedef logic [INTR_W-1:0]      intr_vec_t;
  typedef logic [FAST_INTR_W-1:0] fast_intr_t;
  typedef logic [NUM_TIMERS-1:0]  timer_intr_t;
  typedef logic [NUM_GPIO_AO-1:0] gpio_intr_t;

  // machine interrupt positions in mip/mie
  parameter int unsigned IRQ_SOFTWARE_BIT = 3;
  parameter int unsigned IRQ_TIMER_BIT    = 7;
  parameter int unsigned IRQ_EXTERNAL_BIT = 11;
  parameter int unsigned IRQ_FAST_LSB     = 16;

  typedef enum logic [3:0] {
    // power-down chain
    PWR_ON,
    PWR_CLK_OFF,
    PWR_ISO_ON,
    PWR_RST_ON,
    PWR_SW_OFF,
    PWR_WAIT_OFF,
    PWR_OFF,
    // power-up chain
    PWR_SW_ON,
    PWR_WAIT_ON,
    PWR_RST_OFF,
    PWR_ISO_OFF,
    PWR_CLK_ON,
    // bank kept powered with contents retained
    PWR_RET
  } pwr_state_e;

endpackage

// File: common/pwr_ctrl_if.sv
/* power control of one domain towards its switch cells
   the sequencer drives the seq side, the top maps the top side to pins */

interface pwr_ctrl_if;

  // all active low, switch is on while pwrgate_en_n is low
  logic pwrgate_en_n;
  logic isogate_en_n;
  logic rst_n;
  logic clkgate_en_n;
  logic retentive_en_n;
  // from the switch cells, follows the switch after their delay
  logic pwrgate_ack_n;

  modport seq (
    output pwrgate_en_n,
    output isogate_en_n,
    output rst_n,
    output clkgate_en_n,
    output retentive_en_n,
    input  pwrgate_ack_n
  );

  modport top (
    input  pwrgate_en_n,
    input  isogate_en_n,
    input  rst_n,
    input  clkgate_en_n,
    input  retentive_en_n,
    output pwrgate_ack_n
  );

endinterface

// File: rtl/rst_sync.sv
/* system reset from pad reset and debug non-debug-module reset
   asserts at once, releases two clock edges after both are high */

module rst_sync (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic ndmreset_ni,
  output logic sys_rst_no
);

  logic       rst_comb_n;
  logic [1:0] sync_q;

  assign rst_comb_n = arst_n_i & ndmreset_ni;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

  a_pad_rst_asserts: assert property (@(posedge clk_i) !arst_n_i |-> !sys_rst_no);

endmodule

// File: rtl/irq_router.sv
/* machine interrupt vector assembly
   packs timer, software, external and fast sources, registers them and flags wake */

module irq_router
  import mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  timer_intr_t timer_intr_i,
  input  logic        irq_software_i,
  input  logic        irq_external_i,
  input  logic        dma_done_intr_i,
  input  logic        dma_window_intr_i,
  input  logic        spi_intr_i,
  input  logic        spi_flash_intr_i,
  input  gpio_intr_t  gpio_ao_intr_i,
  output intr_vec_t   irq_o,
  output logic        wake_o
);

  fast_intr_t fast_intr;
  intr_vec_t  irq_d;

  // from bit 16 up: timers 1..3, dma done, spi, spi flash, gpio ao, dma window
  assign fast_intr = {dma_window_intr_i, gpio_ao_intr_i, spi_flash_intr_i, spi_intr_i,
                      dma_done_intr_i, timer_intr_i[3:1]};

  always_comb begin
    irq_d                                  = '0;
    irq_d[IRQ_SOFTWARE_BIT]                = irq_software_i;
    irq_d[IRQ_TIMER_BIT]                   = timer_intr_i[0];
    irq_d[IRQ_EXTERNAL_BIT]                = irq_external_i;
    irq_d[IRQ_FAST_LSB +: FAST_INTR_W]     = fast_intr;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_o <= '0;
    end else begin
      irq_o <= irq_d;
    end
  end

  assign wake_o = |irq_o;

  a_bit31_clear: assert property (@(posedge clk_i) disable iff (!arst_n_i) !irq_o[31]);

endmodule

// File: power_manager/pwr_domain_fsm.sv
/* power sequencer for one switchable domain
   steps clock gate, isolation, reset and switch in order; banks can park in retention */

module pwr_domain_fsm
  import mcu_pkg::*;
#(
  parameter int unsigned RETENTION = 0
) (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    off_req_i,
  input  logic    ret_req_i,
  pwr_ctrl_if.seq pwr
);

  pwr_state_e state_q;
  pwr_state_e state_d;

  logic pwrgate_en_n_d;
  logic isogate_en_n_d;
  logic rst_n_d;
  logic clkgate_en_n_d;
  logic retentive_en_n_d;

  // requests are only looked at in the resting states
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      PWR_ON:       if (off_req_i) state_d = PWR_CLK_OFF;
      PWR_CLK_OFF:  state_d = PWR_ISO_ON;
      PWR_ISO_ON:   state_d = PWR_RST_ON;
      PWR_RST_ON:   state_d = (RETENTION != 0 && ret_req_i) ? PWR_RET : PWR_SW_OFF;
      PWR_SW_OFF:   state_d = PWR_WAIT_OFF;
      PWR_WAIT_OFF: if (pwr.pwrgate_ack_n) state_d = PWR_OFF;
      PWR_OFF:      if (!off_req_i) state_d = PWR_SW_ON;
      PWR_SW_ON:    state_d = PWR_WAIT_ON;
      PWR_WAIT_ON:  if (!pwr.pwrgate_ack_n) state_d = PWR_RST_OFF;
      PWR_RST_OFF:  state_d = PWR_ISO_OFF;
      PWR_ISO_OFF:  state_d = PWR_CLK_ON;
      PWR_CLK_ON:   state_d = PWR_ON;
      // switch never went off, so skip straight to reset release
      PWR_RET:      if (!off_req_i) state_d = PWR_RST_OFF;
      default:      state_d = PWR_ON;
    endcase
  end

  // controls follow the state being entered
  always_comb begin
    clkgate_en_n_d   = state_d inside {PWR_ON, PWR_CLK_ON};
    isogate_en_n_d   = state_d inside {PWR_ON, PWR_CLK_OFF, PWR_ISO_OFF, PWR_CLK_ON};
    rst_n_d          = state_d inside {PWR_ON, PWR_CLK_OFF, PWR_ISO_ON,
                                       PWR_RST_OFF, PWR_ISO_OFF, PWR_CLK_ON};
    pwrgate_en_n_d   = state_d inside {PWR_SW_OFF, PWR_WAIT_OFF, PWR_OFF};
    retentive_en_n_d = (state_d != PWR_RET);
  end

  // domain reset held low until the first edge after system reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q            <= PWR_ON;
      pwr.pwrgate_en_n   <= 1'b0;
      pwr.isogate_en_n   <= 1'b1;
      pwr.rst_n          <= 1'b0;
      pwr.clkgate_en_n   <= 1'b1;
      pwr.retentive_en_n <= 1'b1;
    end else begin
      state_q            <= state_d;
      pwr.pwrgate_en_n   <= pwrgate_en_n_d;
      pwr.isogate_en_n   <= isogate_en_n_d;
      pwr.rst_n          <= rst_n_d;
      pwr.clkgate_en_n   <= clkgate_en_n_d;
      pwr.retentive_en_n <= retentive_en_n_d;
    end
  end

  // an unpowered domain must never drive unclamped outputs
  a_iso_when_off: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    pwr.pwrgate_en_n |-> !pwr.isogate_en_n
  );

endmodule

// File: power_manager/power_manager.sv
/* power manager for the cpu, peripheral and memory bank domains
   one sequencer per domain; cpu sleeps on core sleep and wakes on any interrupt */

module power_manager
  import mcu_pkg::*;
#(
  parameter int unsigned NUM_BANKS = mcu_pkg::NUM_BANKS
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 core_sleep_i,
  input  logic                 wake_i,
  input  logic                 periph_off_req_i,
  input  logic [NUM_BANKS-1:0] bank_off_req_i,
  input  logic [NUM_BANKS-1:0] bank_ret_req_i,
  pwr_ctrl_if.seq              cpu,
  pwr_ctrl_if.seq              periph,
  pwr_ctrl_if.seq              bank [NUM_BANKS-1:0]
);

  logic cpu_off_req;

  // a pending interrupt keeps the core powered
  assign cpu_off_req = core_sleep_i & ~wake_i;

  pwr_domain_fsm #(
    .RETENTION(0)
  ) u_cpu_fsm (
    .clk_i,
    .arst_n_i,
    .off_req_i(cpu_off_req),
    .ret_req_i(1'b0),
    .pwr      (cpu)
  );

  pwr_domain_fsm #(
    .RETENTION(0)
  ) u_periph_fsm (
    .clk_i,
    .arst_n_i,
    .off_req_i(periph_off_req_i),
    .ret_req_i(1'b0),
    .pwr      (periph)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    pwr_domain_fsm #(
      .RETENTION(1)
    ) u_bank_fsm (
      .clk_i,
      .arst_n_i,
      .off_req_i(bank_off_req_i[i]),
      .ret_req_i(bank_ret_req_i[i]),
      .pwr      (bank[i])
    );
  end

endmodule

// File: rtl/mcu_ao_top.sv
/* always-on glue of the microcontroller
   reset generation, interrupt vector and power manager brought out to plain pins */

module mcu_ao_top
  import mcu_pkg::*;
#(
  parameter int unsigned NUM_BANKS = mcu_pkg::NUM_BANKS
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 ndmreset_ni,
  input  logic                 core_sleep_i,

  input  timer_intr_t          timer_intr_i,
  input  logic                 irq_software_i,
  input  logic                 irq_external_i,
  input  logic                 dma_done_intr_i,
  input  logic                 dma_window_intr_i,
  input  logic                 spi_intr_i,
  input  logic                 spi_flash_intr_i,
  input  gpio_intr_t           gpio_ao_intr_i,

  input  logic                 periph_off_req_i,
  input  logic [NUM_BANKS-1:0] bank_off_req_i,
  input  logic [NUM_BANKS-1:0] bank_ret_req_i,

  input  logic                 cpu_switch_ack_ni,
  input  logic                 periph_switch_ack_ni,
  input  logic [NUM_BANKS-1:0] bank_switch_ack_ni,

  output intr_vec_t            irq_o,

  output logic                 cpu_switch_no,
  output logic                 cpu_iso_no,
  output logic                 cpu_rst_no,

  output logic                 periph_switch_no,
  output logic                 periph_iso_no,
  output logic                 periph_rst_no,
  output logic                 periph_clkgate_en_no,

  output logic [NUM_BANKS-1:0] bank_switch_no,
  output logic [NUM_BANKS-1:0] bank_iso_no,
  output logic [NUM_BANKS-1:0] bank_retentive_no,
  output logic [NUM_BANKS-1:0] bank_clkgate_en_no
);

  logic sys_rst_n;
  logic wake;

  pwr_ctrl_if cpu_pwr ();
  pwr_ctrl_if periph_pwr ();
  pwr_ctrl_if bank_pwr [NUM_BANKS-1:0] ();

  rst_sync u_rst_sync (
    .clk_i,
    .arst_n_i,
    .ndmreset_ni,
    .sys_rst_no(sys_rst_n)
  );

  irq_router u_irq_router (
    .clk_i,
    .arst_n_i(sys_rst_n),
    .timer_intr_i,
    .irq_software_i,
    .irq_external_i,
    .dma_done_intr_i,
    .dma_window_intr_i,
    .spi_intr_i,
    .spi_flash_intr_i,
    .gpio_ao_intr_i,
    .irq_o,
    .wake_o  (wake)
  );

  power_manager #(
    .NUM_BANKS(NUM_BANKS)
  ) u_power_manager (
    .clk_i,
    .arst_n_i(sys_rst_n),
    .core_sleep_i,
    .wake_i  (wake),
    .periph_off_req_i,
    .bank_off_req_i,
    .bank_ret_req_i,
    .cpu     (cpu_pwr),
    .periph  (periph_pwr),
    .bank    (bank_pwr)
  );

  // switch cells and isolation are outside, so every control goes to a pin
  assign cpu_switch_no           = cpu_pwr.pwrgate_en_n;
  assign cpu_iso_no              = cpu_pwr.isogate_en_n;
  assign cpu_rst_no              = cpu_pwr.rst_n;
  assign cpu_pwr.pwrgate_ack_n   = cpu_switch_ack_ni;

  assign periph_switch_no         = periph_pwr.pwrgate_en_n;
  assign periph_iso_no            = periph_pwr.isogate_en_n;
  assign periph_rst_no            = periph_pwr.rst_n;
  assign periph_clkgate_en_no     = periph_pwr.clkgate_en_n;
  assign periph_pwr.pwrgate_ack_n = periph_switch_ack_ni;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank_pins
    assign bank_switch_no[i]         = bank_pwr[i].pwrgate_en_n;
    assign bank_iso_no[i]            = bank_pwr[i].isogate_en_n;
    assign bank_retentive_no[i]      = bank_pwr[i].retentive_en_n;
    assign bank_clkgate_en_no[i]     = bank_pwr[i].clkgate_en_n;
    assign bank_pwr[i].pwrgate_ack_n = bank_switch_ack_ni[i];
  end

endmodule

// File: bench/tb_cases.svh
/* interrupt stimulus rows with expected vectors, plus periph power step patterns
   rows with rand_gpio set get a random gpio_ao pattern on top of the expected vector */
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

typedef struct packed {
  timer_intr_t timer;
  logic        software;
  logic        external;
  logic        dma_done;
  logic        spi;
  logic        spi_flash;
  logic        dma_window;
  logic        rand_gpio;
  intr_vec_t   expected;
} irq_case_t;

localparam int unsigned NUM_CASES = 16;

// timer, sw, ext, dma_done, spi, spi_flash, dma_window, rand_gpio, expected irq_o
localparam irq_case_t CASES [NUM_CASES] = '{
  '{4'b0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0000},
  '{4'b0000, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0008},
  '{4'b0001, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0080},
  '{4'b0000, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0800},
  '{4'b0010, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0001_0000},
  '{4'b0100, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0002_0000},
  '{4'b1000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0004_0000},
  '{4'b0000, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0008_0000},
  '{4'b0000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0010_0000},
  '{4'b0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0020_0000},
  '{4'b0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 32'h4000_0000},
  '{4'b0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_0000},
  '{4'b1111, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 32'h403F_0888},
  '{4'b0101, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0002_0080},
  '{4'b0000, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_0808},
  '{4'b0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0000}
};

// periph {clkgate, iso, rst, switch} on each cycle after the off request
localparam logic [3:0] PERIPH_DOWN_STEPS [4] = '{4'b0110, 4'b0010, 4'b0000, 4'b0001};
// from the cycle the domain reset comes back
localparam logic [3:0] PERIPH_UP_STEPS [3] = '{4'b0010, 4'b0110, 4'b1110};

`endif

// File: bench/tb_mcu_ao_top.sv
/* testbench for the always-on glue: interrupt table, periph, bank and cpu power
   sequences against a switch-cell model, and a debug reset pulse */

module tb_mcu_ao_top
  import mcu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  `include "tb_cases.svh"

  localparam int unsigned RESET_CYCLES = 3;
  // longest single power sequence, acknowledge delay included
  localparam int unsigned LONGEST_SEQ = 14;
  localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + NUM_CASES + 8 * LONGEST_SEQ + 40;
  // gpio_ao bit 0 sits after timers 1..3, dma done, spi and spi flash
  localparam int unsigned GPIO_VEC_LSB = 22;
  localparam int unsigned RET_BANK = 2;

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic                 ndmreset_n;
  logic                 core_sleep;
  timer_intr_t          timer_intr;
  logic                 irq_software;
  logic                 irq_external;
  logic                 dma_done_intr;
  logic                 dma_window_intr;
  logic                 spi_intr;
  logic                 spi_flash_intr;
  gpio_intr_t           gpio_ao_intr;
  logic                 periph_off_req;
  logic [NUM_BANKS-1:0] bank_off_req;
  logic [NUM_BANKS-1:0] bank_ret_req;
  // switch-cell model, two stages per domain
  logic                 cpu_sw_q = 1'b0;
  logic                 cpu_ack_n = 1'b0;
  logic                 periph_sw_q = 1'b0;
  logic                 periph_ack_n = 1'b0;
  logic [NUM_BANKS-1:0] bank_sw_q = '0;
  logic [NUM_BANKS-1:0] bank_ack_n = '0;

  intr_vec_t            irq;
  logic                 cpu_switch_n;
  logic                 cpu_iso_n;
  logic                 cpu_rst_n;
  logic                 periph_switch_n;
  logic                 periph_iso_n;
  logic                 periph_rst_n;
  logic                 periph_clkgate_n;
  logic [NUM_BANKS-1:0] bank_switch_n;
  logic [NUM_BANKS-1:0] bank_iso_n;
  logic [NUM_BANKS-1:0] bank_retentive_n;
  logic [NUM_BANKS-1:0] bank_clkgate_n;

  int unsigned cycle_cnt = 0;
  int unsigned err_cnt = 0;
  int unsigned seed_val;
  gpio_intr_t  gpio_pat;
  intr_vec_t   exp_vec;

  mcu_ao_top #(
    .NUM_BANKS(NUM_BANKS)
  ) UUT (
    .clk_i               (clk),
    .arst_n_i            (arst_n),
    .ndmreset_ni         (ndmreset_n),
    .core_sleep_i        (core_sleep),
    .timer_intr_i        (timer_intr),
    .irq_software_i      (irq_software),
    .irq_external_i      (irq_external),
    .dma_done_intr_i     (dma_done_intr),
    .dma_window_intr_i   (dma_window_intr),
    .spi_intr_i          (spi_intr),
    .spi_flash_intr_i    (spi_flash_intr),
    .gpio_ao_intr_i      (gpio_ao_intr),
    .periph_off_req_i    (periph_off_req),
    .bank_off_req_i      (bank_off_req),
    .bank_ret_req_i      (bank_ret_req),
    .cpu_switch_ack_ni   (cpu_ack_n),
    .periph_switch_ack_ni(periph_ack_n),
    .bank_switch_ack_ni  (bank_ack_n),
    .irq_o               (irq),
    .cpu_switch_no       (cpu_switch_n),
    .cpu_iso_no          (cpu_iso_n),
    .cpu_rst_no          (cpu_rst_n),
    .periph_switch_no    (periph_switch_n),
    .periph_iso_no       (periph_iso_n),
    .periph_rst_no       (periph_rst_n),
    .periph_clkgate_en_no(periph_clkgate_n),
    .bank_switch_no      (bank_switch_n),
    .bank_iso_no         (bank_iso_n),
    .bank_retentive_no   (bank_retentive_n),
    .bank_clkgate_en_no  (bank_clkgate_n)
  );

  always #50 clk = ~clk;

  // acknowledge follows the switch two cycles later
  always @(negedge clk) begin
    cpu_sw_q     <= cpu_switch_n;
    cpu_ack_n    <= cpu_sw_q;
    periph_sw_q  <= periph_switch_n;
    periph_ack_n <= periph_sw_q;
    bank_sw_q    <= bank_switch_n;
    bank_ack_n   <= bank_sw_q;
  end

  always @(posedge clk) begin
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      stop_with_error($sformatf("timeout: the run did not end within %0d cycles",
                                TIMEOUT_CYCLES));
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_vec(input intr_vec_t got, input intr_vec_t exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      stop_with_error($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      stop_with_error($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // exp is {clkgate, iso, rst, switch}
  task automatic check_periph(input logic [3:0] exp, input string when);
    check_bit(periph_clkgate_n, exp[3], {when, ": periph_clkgate_en_no"});
    check_bit(periph_iso_n, exp[2], {when, ": periph_iso_no"});
    check_bit(periph_rst_n, exp[1], {when, ": periph_rst_no"});
    check_bit(periph_switch_n, exp[0], {when, ": periph_switch_no"});
  endtask

  task automatic apply_irq_row(input irq_case_t row, input gpio_intr_t gpio);
    timer_intr      = row.timer;
    irq_software    = row.software;
    irq_external    = row.external;
    dma_done_intr   = row.dma_done;
    spi_intr        = row.spi;
    spi_flash_intr  = row.spi_flash;
    dma_window_intr = row.dma_window;
    gpio_ao_intr    = gpio;
  endtask

  initial begin
    seed_val = $urandom(32'hb7bd);
    arst_n = 1'b0;
    ndmreset_n = 1'b1;
    core_sleep = 1'b0;
    periph_off_req = 1'b0;
    bank_off_req = '0;
    bank_ret_req = '0;
    apply_irq_row('0, '0);

    repeat (RESET_CYCLES) @(negedge clk);
    check_bit(cpu_rst_n, 1'b0, "cpu_rst_no in reset");
    arst_n = 1'b1;
    while (cpu_rst_n !== 1'b1) @(negedge clk);
    check_bit(cpu_switch_n, 1'b0, "cpu_switch_no after reset");
    check_bit(cpu_iso_n, 1'b1, "cpu_iso_no after reset");
    check_periph(4'b1110, "after reset");
    for (int b = 0; b < NUM_BANKS; b++) begin
      check_bit(bank_switch_n[b], 1'b0, $sformatf("bank %0d switch after reset", b));
      check_bit(bank_iso_n[b], 1'b1, $sformatf("bank %0d iso after reset", b));
      check_bit(bank_clkgate_n[b], 1'b1, $sformatf("bank %0d clkgate after reset", b));
      check_bit(bank_retentive_n[b], 1'b1, $sformatf("bank %0d retention after reset", b));
    end
    check_vec(irq, '0, "irq_o after reset");

    for (int i = 0; i < NUM_CASES; i++) begin
      gpio_pat = CASES[i].rand_gpio ? gpio_intr_t'($urandom()) : '0;
      apply_irq_row(CASES[i], gpio_pat);
      exp_vec = CASES[i].expected | (intr_vec_t'(gpio_pat) << GPIO_VEC_LSB);
      @(negedge clk);
      check_vec(irq, exp_vec, $sformatf("irq_o row %0d", i));
    end
    apply_irq_row('0, '0);
    @(negedge clk);

    periph_off_req = 1'b1;
    for (int s = 0; s < 4; s++) begin
      @(negedge clk);
      check_periph(PERIPH_DOWN_STEPS[s], $sformatf("periph power-down step %0d", s));
    end
    while (periph_ack_n !== 1'b1) @(negedge clk);
    periph_off_req = 1'b0;
    while (periph_rst_n !== 1'b1) @(negedge clk);
    check_bit(periph_ack_n, 1'b0, "periph acknowledge before reset release");
    for (int s = 0; s < 3; s++) begin
      if (s > 0) @(negedge clk);
      check_periph(PERIPH_UP_STEPS[s], $sformatf("periph power-up step %0d", s));
    end

    bank_ret_req[RET_BANK] = 1'b1;
    bank_off_req = '1;
    while (bank_switch_n[0] !== 1'b1) @(negedge clk);
    for (int b = 0; b < NUM_BANKS; b++) begin
      check_bit(bank_retentive_n[b], b != RET_BANK, $sformatf("bank %0d retention", b));
      check_bit(bank_switch_n[b], b != RET_BANK, $sformatf("bank %0d switch", b));
      check_bit(bank_iso_n[b], 1'b0, $sformatf("bank %0d iso while down", b));
    end
    bank_off_req = '0;
    bank_ret_req = '0;
    while (bank_clkgate_n !== '1) @(negedge clk);
    for (int b = 0; b < NUM_BANKS; b++) begin
      check_bit(bank_retentive_n[b], 1'b1, $sformatf("bank %0d retention after wake", b));
      check_bit(bank_switch_n[b], 1'b0, $sformatf("bank %0d switch after wake", b));
      check_bit(bank_iso_n[b], 1'b1, $sformatf("bank %0d iso after wake", b));
    end

    // core sleeps with nothing pending, one interrupt brings it back
    core_sleep = 1'b1;
    while (cpu_switch_n !== 1'b1) @(negedge clk);
    check_bit(cpu_iso_n, 1'b0, "cpu_iso_no while cpu off");
    check_bit(cpu_rst_n, 1'b0, "cpu_rst_no while cpu off");
    irq_external = 1'b1;
    while (cpu_rst_n !== 1'b1) @(negedge clk);
    check_bit(cpu_switch_n, 1'b0, "cpu_switch_no after wake");
    core_sleep = 1'b0;
    apply_irq_row('0, '0);
    while (cpu_iso_n !== 1'b1) @(negedge clk);

    ndmreset_n = 1'b0;
    @(negedge clk);
    check_bit(cpu_rst_n, 1'b0, "cpu_rst_no in debug reset");
    check_bit(periph_rst_n, 1'b0, "periph_rst_no in debug reset");
    ndmreset_n = 1'b1;
    while (cpu_rst_n !== 1'b1 || periph_rst_n !== 1'b1) @(negedge clk);
    check_bit(cpu_switch_n, 1'b0, "cpu_switch_no after debug reset");
    check_bit(periph_switch_n, 1'b0, "periph_switch_no after debug reset");

    if (err_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

endmodule

// File: all.f
+incdir+bench
common/mcu_pkg.sv
common/pwr_ctrl_if.sv
rtl/rst_sync.sv
rtl/irq_router.sv
power_manager/pwr_domain_fsm.sv
power_manager/power_manager.sv
rtl/mcu_ao_top.sv
bench/tb_mcu_ao_top.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= tb_mcu_ao_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := bench/tb_cases.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
